/* Makefile */
SOURCES := $(wildcard source/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_rv_core: src.f $(SOURCES)
	verilator --binary --timing --assert -f src.f --top-module tb_rv_core -o Vtb_rv_core

sim.log: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core > sim.log

run: sim.log
	cat sim.log
	! grep -q "Test FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

/* source/rv_core_top.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [rv_isa_pkg::XLEN-1:0] i_imem_data,
    output logic [rv_isa_pkg::XLEN-1:0] o_imem_addr,
    output logic                        o_uart_en,
    output logic [7:0]                  o_uart_data
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0]           pc;
    logic [XLEN-1:0]           next_pc;
    op_e                       op;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    logic [XLEN-1:0]           imm;
    logic [XLEN-1:0]           rs1_val;
    logic [XLEN-1:0]           rs2_val;
    logic [XLEN-1:0]           alu_result;
    logic [XLEN-1:0]           load_val;
    logic [XLEN-1:0]           wb_data;
    logic                      reg_we;
    logic                      is_load;

    always_ff @(posedge clk) begin
        if (reset) pc <= '0;
        else       pc <= next_pc;
    end

    assign o_imem_addr = pc;

    rv_decoder u_decoder (
        .i_instr (i_imem_data),
        .o_op    (op),
        .o_rd    (rd),
        .o_rs1   (rs1),
        .o_rs2   (rs2),
        .o_imm   (imm)
    );

    rv_regfile u_regfile (
        .clk       (clk),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .i_rd      (rd),
        .i_we      (reg_we),
        .i_wdata   (wb_data),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val)
    );

    rv_execute u_execute (
        .i_op      (op),
        .i_pc      (pc),
        .i_rs1_val (rs1_val),
        .i_rs2_val (rs2_val),
        .i_imm     (imm),
        .o_result  (alu_result),
        .o_reg_we  (reg_we),
        .o_next_pc (next_pc)
    );

    rv_lsu u_lsu (
        .clk         (clk),
        .reset       (reset),
        .i_op        (op),
        .i_addr      (alu_result), // effective address
        .i_store_val (rs2_val),
        .o_load_val  (load_val),
        .o_uart_en   (o_uart_en),
        .o_uart_data (o_uart_data)
    );

    assign is_load = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign wb_data = is_load ? load_val : alu_result;

    // jump targets from execute keep fetch word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* source/rv_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_decoder (
    input  logic [rv_isa_pkg::XLEN-1:0]           i_instr,
    output rv_isa_pkg::op_e                       o_op,
    output logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] o_rd,
    output logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] o_rs1,
    output logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] o_rs2,
    output logic [rv_isa_pkg::XLEN-1:0]           o_imm
);
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rd   = i_instr[11:7];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'h000};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: o_imm = imm_u;
            OPC_JAL:            o_imm = imm_j;
            OPC_BRANCH:         o_imm = imm_b;
            OPC_STORE:          o_imm = imm_s;
            default:            o_imm = imm_i; // shifts take shamt from imm[4:0]
        endcase
    end

    always_comb begin
        o_op = OP_NONE;
        case (opcode)
            OPC_LUI:   o_op = OP_LUI;
            OPC_AUIPC: o_op = OP_AUIPC;
            OPC_JAL:   o_op = OP_JAL;
            OPC_JALR:  if (funct3 == F3_JALR) o_op = OP_JALR;
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  o_op = OP_BEQ;
                    F3_BNE:  o_op = OP_BNE;
                    F3_BLT:  o_op = OP_BLT;
                    F3_BGE:  o_op = OP_BGE;
                    F3_BLTU: o_op = OP_BLTU;
                    F3_BGEU: o_op = OP_BGEU;
                    default: o_op = OP_NONE;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_LB:   o_op = OP_LB;
                    F3_LH:   o_op = OP_LH;
                    F3_LW:   o_op = OP_LW;
                    F3_LBU:  o_op = OP_LBU;
                    F3_LHU:  o_op = OP_LHU;
                    default: o_op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_SB:   o_op = OP_SB;
                    F3_SH:   o_op = OP_SH;
                    F3_SW:   o_op = OP_SW;
                    default: o_op = OP_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD:  o_op = OP_ADDI;
                    F3_SLT:  o_op = OP_SLTI;
                    F3_SLTU: o_op = OP_SLTIU;
                    F3_XOR:  o_op = OP_XORI;
                    F3_OR:   o_op = OP_ORI;
                    F3_AND:  o_op = OP_ANDI;
                    F3_SLL:  if (funct7 == 7'b0) o_op = OP_SLLI;
                    F3_SR: begin
                        if (funct7 == 7'b0)            o_op = OP_SRLI;
                        else if (funct7 == FUNCT7_ALT) o_op = OP_SRAI;
                    end
                    default: o_op = OP_NONE;
                endcase
            end
            OPC_OP: begin
                if (funct7 == 7'b0) begin
                    case (funct3)
                        F3_ADD:  o_op = OP_ADD;
                        F3_SLL:  o_op = OP_SLL;
                        F3_SLT:  o_op = OP_SLT;
                        F3_SLTU: o_op = OP_SLTU;
                        F3_XOR:  o_op = OP_XOR;
                        F3_SR:   o_op = OP_SRL;
                        F3_OR:   o_op = OP_OR;
                        default: o_op = OP_AND;
                    endcase
                end else if (funct7 == FUNCT7_ALT) begin
                    if (funct3 == F3_ADD)     o_op = OP_SUB;
                    else if (funct3 == F3_SR) o_op = OP_SRA;
                end
            end
            default: o_op = OP_NONE; // unknown acts as nop
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_execute.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_execute (
    input  rv_isa_pkg::op_e             i_op,
    input  logic [rv_isa_pkg::XLEN-1:0] i_pc,
    input  logic [rv_isa_pkg::XLEN-1:0] i_rs1_val,
    input  logic [rv_isa_pkg::XLEN-1:0] i_rs2_val,
    input  logic [rv_isa_pkg::XLEN-1:0] i_imm,
    output logic [rv_isa_pkg::XLEN-1:0] o_result,
    output logic                        o_reg_we,
    output logic [rv_isa_pkg::XLEN-1:0] o_next_pc
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] addr_sum; // rs1 + imm, also the load/store address
    logic [XLEN-1:0] target;
    logic            taken;
    logic            lt_s;
    logic            lt_u;
    logic            lti_s;
    logic            lti_u;

    assign pc_plus4 = i_pc + XLEN'(4);
    assign addr_sum = i_rs1_val + i_imm;

    assign lt_s  = $signed(i_rs1_val) < $signed(i_rs2_val);
    assign lt_u  = i_rs1_val < i_rs2_val;
    assign lti_s = $signed(i_rs1_val) < $signed(i_imm);
    assign lti_u = i_rs1_val < i_imm;

    always_comb begin
        o_result = '0;
        o_reg_we = 1'b1;
        case (i_op)
            OP_ADD:   o_result = i_rs1_val + i_rs2_val;
            OP_SUB:   o_result = i_rs1_val - i_rs2_val;
            OP_XOR:   o_result = i_rs1_val ^ i_rs2_val;
            OP_OR:    o_result = i_rs1_val | i_rs2_val;
            OP_AND:   o_result = i_rs1_val & i_rs2_val;
            OP_SLL:   o_result = i_rs1_val << i_rs2_val[4:0];
            OP_SRL:   o_result = i_rs1_val >> i_rs2_val[4:0];
            OP_SRA:   o_result = $signed(i_rs1_val) >>> i_rs2_val[4:0];
            OP_SLT:   o_result = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU:  o_result = {{(XLEN-1){1'b0}}, lt_u};
            OP_ADDI:  o_result = addr_sum;
            OP_XORI:  o_result = i_rs1_val ^ i_imm;
            OP_ORI:   o_result = i_rs1_val | i_imm;
            OP_ANDI:  o_result = i_rs1_val & i_imm;
            OP_SLLI:  o_result = i_rs1_val << i_imm[4:0];
            OP_SRLI:  o_result = i_rs1_val >> i_imm[4:0];
            OP_SRAI:  o_result = $signed(i_rs1_val) >>> i_imm[4:0];
            OP_SLTI:  o_result = {{(XLEN-1){1'b0}}, lti_s};
            OP_SLTIU: o_result = {{(XLEN-1){1'b0}}, lti_u};
            OP_LUI:   o_result = i_imm;
            OP_AUIPC: o_result = i_pc + i_imm;
            OP_JAL, OP_JALR: o_result = pc_plus4; // link
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: o_result = addr_sum;
            OP_SB, OP_SH, OP_SW: begin
                o_result = addr_sum;
                o_reg_we = 1'b0;
            end
            default: o_reg_we = 1'b0; // branches and nop
        endcase
    end

    always_comb begin
        taken  = 1'b0;
        target = i_pc + i_imm;
        case (i_op)
            OP_BEQ:  taken = (i_rs1_val == i_rs2_val);
            OP_BNE:  taken = (i_rs1_val != i_rs2_val);
            OP_BLT:  taken = lt_s;
            OP_BGE:  taken = !lt_s;
            OP_BLTU: taken = lt_u;
            OP_BGEU: taken = !lt_u;
            OP_JAL:  taken = 1'b1;
            OP_JALR: begin
                taken  = 1'b1;
                target = {addr_sum[XLEN-1:1], 1'b0};
            end
            default: taken = 1'b0;
        endcase
    end

    assign o_next_pc = taken ? target : pc_plus4;

endmodule

`default_nettype wire

/* source/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // alu funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // sub, sra

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

    typedef enum logic [5:0] {
        OP_NONE,
        OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW
    } op_e;

endpackage

`default_nettype wire

/* source/rv_lsu.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_lsu (
    input  logic                        clk,
    input  logic                        reset,
    input  rv_isa_pkg::op_e             i_op,
    input  logic [rv_isa_pkg::XLEN-1:0] i_addr,
    input  logic [rv_isa_pkg::XLEN-1:0] i_store_val,
    output logic [rv_isa_pkg::XLEN-1:0] o_load_val,
    output logic                        o_uart_en,
    output logic [7:0]                  o_uart_data
);
    import rv_isa_pkg::*;
    import rv_soc_pkg::*;

    logic [XLEN-1:0] mem [0:DMEM_WORDS-1];

    logic [DMEM_ADDR_WIDTH-1:0] word_addr;
    logic [3:0]                 byte_en;
    logic [4:0]                 lane_shift;
    logic [XLEN-1:0]            store_data;
    logic [XLEN-1:0]            rdata;
    logic [XLEN-1:0]            lane;
    logic                       is_store;
    logic                       is_mmio;
    logic                       active;
    logic                       mem_we;

    assign word_addr  = i_addr[DMEM_ADDR_WIDTH+1:2];
    assign lane_shift = {i_addr[1:0], 3'b000};
    assign is_store   = (i_op == OP_SB) || (i_op == OP_SH) || (i_op == OP_SW);
    assign is_mmio    = (i_addr >= MMIO_BASE);
    assign active     = !reset; // nothing commits while in reset
    assign mem_we     = active && is_store && !is_mmio;

    // lane placement from the low address bits
    always_comb begin
        byte_en    = 4'b0000;
        store_data = i_store_val;
        case (i_op)
            OP_SB: begin
                byte_en    = 4'b0001 << i_addr[1:0];
                store_data = i_store_val << lane_shift;
            end
            OP_SH: begin
                byte_en    = 4'b0011 << {i_addr[1], 1'b0};
                store_data = i_store_val << {i_addr[1], 4'b0000};
            end
            OP_SW:   byte_en = 4'b1111;
            default: byte_en = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) mem[word_addr][8*b +: 8] <= store_data[8*b +: 8];
            end
        end
    end

    // combinational read, shifted down to the addressed lane
    assign rdata = mem[word_addr];
    assign lane  = rdata >> lane_shift;

    always_comb begin
        case (i_op)
            OP_LB:   o_load_val = {{24{lane[7]}}, lane[7:0]};
            OP_LBU:  o_load_val = {24'h000000, lane[7:0]};
            OP_LH:   o_load_val = {{16{lane[15]}}, lane[15:0]};
            OP_LHU:  o_load_val = {16'h0000, lane[15:0]};
            OP_LW:   o_load_val = rdata;
            default: o_load_val = '0;
        endcase
    end

    assign o_uart_en   = active && (i_op == OP_SB) && (i_addr == UART_TX_ADDR);
    assign o_uart_data = i_store_val[7:0];

    // an sb replaces only the addressed byte of its word
    a_sb_lane: assert property (@(posedge clk) disable iff (reset)
        (mem_we && i_op == OP_SB) |=> mem[$past(word_addr)] ==
            (($past(rdata) & ~(XLEN'(8'hFF) << $past(lane_shift))) |
             (XLEN'($past(i_store_val[7:0])) << $past(lane_shift))));

    // mmio stores leave the addressed word untouched
    a_mmio_no_write: assert property (@(posedge clk) disable iff (reset)
        (is_store && is_mmio) |=> (mem[$past(word_addr)] == $past(rdata)));

endmodule

`default_nettype wire

/* source/rv_regfile.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_regfile (
    input  logic                                  clk,
    input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] i_rs1,
    input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] i_rs2,
    input  logic [rv_isa_pkg::REG_ADDR_WIDTH-1:0] i_rd,
    input  logic                                  i_we,
    input  logic [rv_isa_pkg::XLEN-1:0]           i_wdata,
    output logic [rv_isa_pkg::XLEN-1:0]           o_rs1_val,
    output logic [rv_isa_pkg::XLEN-1:0]           o_rs2_val
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_val = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_val = (i_rs2 == '0) ? '0 : regs[i_rs2];

    // a written register reads back on both ports one cycle later
    a_write_visible: assert property (@(posedge clk)
        (i_we && i_rd != '0) |=>
            ((i_rs1 != $past(i_rd) || o_rs1_val == $past(i_wdata)) &&
             (i_rs2 != $past(i_rd) || o_rs2_val == $past(i_wdata))));

endmodule

`default_nettype wire

/* source/rv_soc_pkg.sv */
`default_nettype none

package rv_soc_pkg;

    // data memory, word addressed
    localparam int DMEM_ADDR_WIDTH = 10;
    localparam int DMEM_WORDS      = 2 ** DMEM_ADDR_WIDTH;

    // stores from here up never reach the data memory
    localparam logic [31:0] MMIO_BASE = 32'h0001_0000;

    localparam logic [31:0] UART_TX_ADDR = MMIO_BASE;

endpackage

`default_nettype wire

/* src.f */
+incdir+tests
source/rv_isa_pkg.sv
source/rv_soc_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_lsu.sv
source/rv_core_top.sv
tests/tb_rv_core.sv

/* tests/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// bytes the program sends, in order, worked out from the ISA rules
localparam int EXPECT_LEN = 23;

logic [7:0] expect_bytes [EXPECT_LEN] = '{
    8'h5D, 8'h95, 8'hFE, 8'h0F, 8'h90, 8'h01, 8'h00, 8'h9B, 8'h60, // 100 and -7 through the alu
    8'hFF, 8'h82, 8'h7E, 8'hF1, 8'h80, 8'hFF, 8'h80, 8'h7E, 8'h82, // loads of word 0x80F17E82
    8'h14,                                                         // jal at row 68, link 0x114
    8'h20,                                                         // jalr at row 71, link 0x120
    8'hAB, 8'h34, 8'h12                                            // lui 0xAB, auipc 0x12 at 0x134
};

// x10 holds the uart address, x9 a marker byte that must never go out
task automatic load_program();
    add_row("clear word 0", store_word(F3_SW, 0, 0, 0)); // before any mmio access aliases it
    add_row("lui uart base", upper_word(OPC_LUI, 10, int'(UART_TX_ADDR >> 12)));
    add_row("addi x1 100", imm_word(OPC_OP_IMM, F3_ADD, 1, 0, 100));
    add_row("addi x2 -7", imm_word(OPC_OP_IMM, F3_ADD, 2, 0, -7));
    add_row("add", r_word(F3_ADD, 7'b0000000, 3, 1, 2));
    add_row("send add", store_word(F3_SB, 3, 10, 0));
    add_row("sub", r_word(F3_ADD, FUNCT7_ALT, 3, 2, 1));
    add_row("send sub", store_word(F3_SB, 3, 10, 0));
    add_row("addi x4 2", imm_word(OPC_OP_IMM, F3_ADD, 4, 0, 2));
    add_row("sra negative", r_word(F3_SR, FUNCT7_ALT, 3, 2, 4));
    add_row("send sra", store_word(F3_SB, 3, 10, 0));
    add_row("srli 28", imm_word(OPC_OP_IMM, F3_SR, 3, 2, 28));
    add_row("send srli", store_word(F3_SB, 3, 10, 0));
    add_row("sll", r_word(F3_SLL, 7'b0000000, 3, 1, 4));
    add_row("send sll", store_word(F3_SB, 3, 10, 0));
    add_row("slt", r_word(F3_SLT, 7'b0000000, 3, 2, 1));
    add_row("send slt", store_word(F3_SB, 3, 10, 0));
    add_row("sltu", r_word(F3_SLTU, 7'b0000000, 3, 2, 1));
    add_row("send sltu", store_word(F3_SB, 3, 10, 0));
    add_row("xori 255", imm_word(OPC_OP_IMM, F3_XOR, 3, 1, 255));
    add_row("send xori", store_word(F3_SB, 3, 10, 0));
    add_row("and", r_word(F3_AND, 7'b0000000, 3, 1, 2));
    add_row("send and", store_word(F3_SB, 3, 10, 0));
    add_row("lui word", upper_word(OPC_LUI, 5, 'h80F18));
    add_row("addi word", imm_word(OPC_OP_IMM, F3_ADD, 5, 5, -382));
    add_row("sw word", store_word(F3_SW, 5, 0, 0));
    add_row("sw to mmio", store_word(F3_SW, 1, 10, 0)); // aliases word 0, must not land
    add_row("lb lane 0", imm_word(OPC_LOAD, F3_LB, 3, 0, 0));
    add_row("srli 8 of lb", imm_word(OPC_OP_IMM, F3_SR, 3, 3, 8));
    add_row("send lb lane 0", store_word(F3_SB, 3, 10, 0));
    add_row("lbu lane 0", imm_word(OPC_LOAD, F3_LBU, 3, 0, 0));
    add_row("send lbu lane 0", store_word(F3_SB, 3, 10, 0));
    add_row("lb lane 1", imm_word(OPC_LOAD, F3_LB, 3, 0, 1));
    add_row("send lb lane 1", store_word(F3_SB, 3, 10, 0));
    add_row("lbu lane 2", imm_word(OPC_LOAD, F3_LBU, 3, 0, 2));
    add_row("send lbu lane 2", store_word(F3_SB, 3, 10, 0));
    add_row("lb lane 3", imm_word(OPC_LOAD, F3_LB, 3, 0, 3));
    add_row("send lb lane 3", store_word(F3_SB, 3, 10, 0));
    add_row("lh lane 2", imm_word(OPC_LOAD, F3_LH, 3, 0, 2));
    add_row("srli 16 of lh", imm_word(OPC_OP_IMM, F3_SR, 3, 3, 16));
    add_row("send lh lane 2", store_word(F3_SB, 3, 10, 0));
    add_row("lhu lane 2", imm_word(OPC_LOAD, F3_LHU, 3, 0, 2));
    add_row("srli 8 of lhu", imm_word(OPC_OP_IMM, F3_SR, 3, 3, 8));
    add_row("send lhu lane 2", store_word(F3_SB, 3, 10, 0));
    add_row("lh lane 0", imm_word(OPC_LOAD, F3_LH, 3, 0, 0));
    add_row("srli 8 of lh", imm_word(OPC_OP_IMM, F3_SR, 3, 3, 8));
    add_row("send lh lane 0", store_word(F3_SB, 3, 10, 0));
    add_row("lw word", imm_word(OPC_LOAD, F3_LW, 3, 0, 0));
    add_row("send lw", store_word(F3_SB, 3, 10, 0));
    add_row("addi marker", imm_word(OPC_OP_IMM, F3_ADD, 9, 0, 238));
    // per branch: not taken, taken over the marker, marker
    add_row("beq not taken", branch_word(F3_BEQ, 1, 2, 8));
    add_row("beq taken", branch_word(F3_BEQ, 1, 1, 8));
    add_row("marker after beq", store_word(F3_SB, 9, 10, 0));
    add_row("bne not taken", branch_word(F3_BNE, 1, 1, 8));
    add_row("bne taken", branch_word(F3_BNE, 1, 2, 8));
    add_row("marker after bne", store_word(F3_SB, 9, 10, 0));
    add_row("blt not taken", branch_word(F3_BLT, 1, 2, 8));
    add_row("blt taken", branch_word(F3_BLT, 2, 1, 8));
    add_row("marker after blt", store_word(F3_SB, 9, 10, 0));
    add_row("bge not taken", branch_word(F3_BGE, 2, 1, 8));
    add_row("bge taken", branch_word(F3_BGE, 1, 2, 8));
    add_row("marker after bge", store_word(F3_SB, 9, 10, 0));
    add_row("bltu not taken", branch_word(F3_BLTU, 2, 1, 8));
    add_row("bltu taken", branch_word(F3_BLTU, 1, 2, 8));
    add_row("marker after bltu", store_word(F3_SB, 9, 10, 0));
    add_row("bgeu not taken", branch_word(F3_BGEU, 1, 2, 8));
    add_row("bgeu taken", branch_word(F3_BGEU, 2, 1, 8));
    add_row("marker after bgeu", store_word(F3_SB, 9, 10, 0));
    add_row("jal x11", jump_word(11, 8));
    add_row("marker after jal", store_word(F3_SB, 9, 10, 0));
    add_row("send jal link", store_word(F3_SB, 11, 10, 0));
    add_row("jalr x13 odd", imm_word(OPC_JALR, F3_JALR, 13, 11, 17)); // bit 0 dropped
    add_row("marker after jalr", store_word(F3_SB, 9, 10, 0));
    add_row("send jalr link", store_word(F3_SB, 13, 10, 0));
    add_row("lui 0xAB", upper_word(OPC_LUI, 14, 'hAB));
    add_row("srli 12 of lui", imm_word(OPC_OP_IMM, F3_SR, 14, 14, 12));
    add_row("send lui", store_word(F3_SB, 14, 10, 0));
    add_row("auipc 0x12", upper_word(OPC_AUIPC, 15, 'h12));
    add_row("send auipc low", store_word(F3_SB, 15, 10, 0));
    add_row("srli 12 of auipc", imm_word(OPC_OP_IMM, F3_SR, 15, 15, 12));
    add_row("send auipc upper", store_word(F3_SB, 15, 10, 0));
endtask

`endif

/* tests/tb_rv_core.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_rv_core;
    import rv_isa_pkg::*;
    import rv_soc_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int MARGIN       = 40;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    logic        uart_en;
    logic [7:0]  uart_data;

    string       row_name [$];
    logic [31:0] row_word [$];
    int          errors;
    int          received;
    int          cycles;
    int          limit;
    logic [31:0] end_addr;

    `include "tb_program.svh"

    rv_core_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .i_imem_data (imem_data),
        .o_imem_addr (imem_addr),
        .o_uart_en   (uart_en),
        .o_uart_data (uart_data)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] r_word(input logic [2:0] f3, input logic [6:0] f7,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] imm_word(input logic [6:0] opc, input logic [2:0] f3,
                                             input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] store_word(input logic [2:0] f3, input int rs2,
                                               input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
                                                input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] upper_word(input logic [6:0] opc, input int rd,
                                               input int imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] jump_word(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic add_row(input string name, input logic [31:0] word);
        row_name.push_back(name);
        row_word.push_back(word);
    endtask

    // past the table the core spins on a self loop
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr < end_addr) return row_word[idx];
        return jump_word(0, 0);
    endfunction

    function automatic string row_label(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr < end_addr) return row_name[idx];
        return "past end of table";
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    initial begin
        errors    = 0;
        received  = 0;
        cycles    = 0;
        reset     = 1'b1;
        imem_data = NOP_INSTR;
        load_program();
        limit    = 4 * row_word.size() + MARGIN;
        end_addr = 32'(4 * row_word.size());

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        #5;
        reset = 1'b0;
        check("pc after reset", 32'h0, imem_addr);

        while (imem_addr < end_addr && cycles < limit) begin
            imem_data = fetch_word(imem_addr);
            #1;
            if (uart_en) begin
                if (received < EXPECT_LEN) begin
                    check(row_label(imem_addr), {24'h0, expect_bytes[received]},
                          {24'h0, uart_data});
                end else begin
                    $display("Extra UART byte %0h sent by row %s", uart_data,
                             row_label(imem_addr));
                    errors++;
                end
                received++;
            end
            @(posedge clk);
            #5;
            cycles++;
        end

        // reset again on a uart store through x10
        reset     = 1'b1;
        imem_data = store_word(F3_SB, 9, 10, 0);
        #1;
        check("uart strobe in reset", 32'h0, {31'h0, uart_en});

        if (imem_addr < end_addr) begin
            $display("Timeout: program did not reach the end of the table in %0d cycles",
                     limit);
            errors++;
        end
        if (received < EXPECT_LEN) begin
            $display("Missing UART bytes: only %0d of %0d arrived", received, EXPECT_LEN);
            errors++;
        end
        $display("Errors: %0d, UART bytes received: %0d of %0d", errors, received, EXPECT_LEN);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
